// File: design/cgra_conf_pkg.sv
`default_nettype none

package cgra_conf_pkg;

  // word type codes, low byte of every configuration word
  typedef enum logic [7:0] {
    NOT_CONF            = 8'd0,
    SET_PE_INSTRUCTION  = 8'd1,
    SET_PE_CONST        = 8'd2,
    SET_PE_PC_MAX       = 8'd3,
    SET_PE_PC_LOOP      = 8'd4,
    SET_PE_STORE_IGNORE = 8'd5,
    SET_NET_PC_MAX      = 8'd6,
    SET_NET_PC_LOOP     = 8'd7,
    NET_SWITCH          = 8'd8
  } conf_type_e;

  // payload as seen by switch memory writes
  typedef struct packed {
    logic [11:0] inst_addr;
    logic [23:0] switch_conf;
  } conf_net_view_t;

  // payload as seen by loop bound writes
  typedef struct packed {
    logic [3:0]  pad;
    logic [31:0] pc_value;
  } conf_pc_view_t;

  typedef union packed {
    conf_net_view_t net;
    conf_pc_view_t  pc;
  } conf_payload_u;

  typedef struct packed {
    conf_payload_u payload;        // [63:28]
    logic [3:0]    thread_id;      // [27:24]
    logic [15:0]   switch_number;  // [23:8]
    conf_type_e    conf_type;      // [7:0]
  } conf_word_t;

  // broadcast bus, one word per valid cycle
  typedef struct packed {
    logic       valid;
    conf_word_t word;
  } conf_bus_t;

endpackage

`default_nettype wire

// File: design/cgra_net_pkg.sv
`default_nettype none

package cgra_net_pkg;

  localparam int PC_W  = 8;  // pc and memory address width
  localparam int SEL_W = 8;  // switch select held per address

  typedef struct packed {
    logic             we;
    logic [PC_W-1:0]  addr;
    logic [SEL_W-1:0] data;
  } net_mem_wr_t;

  typedef struct packed {
    logic            max_we;
    logic            loop_we;
    logic            thread_we;
    logic [2:0]      thread;
    logic [PC_W-1:0] value;
  } pc_wr_t;

  typedef struct packed {
    logic             active;
    logic [PC_W-1:0]  pc;
    logic [SEL_W-1:0] sel;
    logic [2:0]       thread;
  } switch_state_t;

endpackage

`default_nettype wire

// File: design/conf_ingress.sv
`default_nettype none

module conf_ingress (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      host_req,
  input  cgra_conf_pkg::conf_word_t host_word,
  output logic                      host_ack,
  input  logic                      full,
  output logic                      push,
  output cgra_conf_pkg::conf_word_t push_word
);

  typedef enum logic {
    IDLE,
    ACKED
  } state_t;

  state_t state;

  assign host_ack = (state == ACKED);

  // word is captured together with the push pulse
  always_ff @(posedge clk) begin
    if (state == IDLE && host_req && !full) begin
      push_word <= host_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      push  <= 1'b0;
    end else begin
      push <= 1'b0;  // single cycle pulse
      case (state)
        IDLE: begin
          if (host_req && !full) begin
            push  <= 1'b1;
            state <= ACKED;
          end
        end
        ACKED: begin
          if (!host_req) begin
            state <= IDLE;  // drop ack, host may start a new req
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/conf_fifo.sv
`default_nettype none

module conf_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      push,
  input  cgra_conf_pkg::conf_word_t push_word,
  output logic                      full,
  input  logic                      conf_hold,
  output cgra_conf_pkg::conf_bus_t  conf_bus
);

  import cgra_conf_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  conf_word_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  assign full = (count == CNT_W'(DEPTH));
  assign pop  = (count != '0) && !conf_hold;

  // head goes straight onto the bus and leaves on the same edge
  assign conf_bus.valid = pop;
  assign conf_bus.word  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ingress must see full before it acks another word
  a_no_push_full : assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("conf_fifo: push while full");

endmodule

`default_nettype wire

// File: design/switch_conf_reader.sv
`default_nettype none

module switch_conf_reader #(
  parameter int SWITCH_NUMBER = 0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  cgra_conf_pkg::conf_bus_t  conf_bus,
  output cgra_net_pkg::net_mem_wr_t net_mem_wr,
  output cgra_net_pkg::pc_wr_t      pc_wr
);

  import cgra_conf_pkg::*;
  import cgra_net_pkg::*;

  logic       s1_valid;
  conf_word_t s1_word;
  logic       match;

  assign match = s1_valid && (s1_word.switch_number == 16'(SWITCH_NUMBER));

  // stage one captures the bus word
  always_ff @(posedge clk) begin
    if (conf_bus.valid) begin
      s1_word <= conf_bus.word;
    end
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= conf_bus.valid;
    end
  end

  // stage two filters on switch number and decodes the type
  always_ff @(posedge clk) begin
    net_mem_wr.addr <= s1_word.payload.net.inst_addr[PC_W-1:0];
    net_mem_wr.data <= s1_word.payload.net.switch_conf[SEL_W-1:0];
    pc_wr.value     <= s1_word.payload.pc.pc_value[PC_W-1:0];
    pc_wr.thread    <= s1_word.thread_id[2:0];
    if (rst) begin
      net_mem_wr.we   <= 1'b0;
      pc_wr.max_we    <= 1'b0;
      pc_wr.loop_we   <= 1'b0;
      pc_wr.thread_we <= 1'b0;
    end else begin
      net_mem_wr.we   <= 1'b0;
      pc_wr.max_we    <= 1'b0;
      pc_wr.loop_we   <= 1'b0;
      pc_wr.thread_we <= 1'b0;
      if (match) begin
        case (s1_word.conf_type)
          SET_NET_PC_MAX: begin
            pc_wr.max_we    <= 1'b1;
            pc_wr.thread_we <= 1'b1;
          end
          SET_NET_PC_LOOP: begin
            pc_wr.loop_we   <= 1'b1;
            pc_wr.thread_we <= 1'b1;
          end
          NET_SWITCH: begin
            net_mem_wr.we   <= 1'b1;
            pc_wr.thread_we <= 1'b1;
          end
          default: begin
          end  // pe types belong to other readers
        endcase
      end
    end
  end

  a_one_strobe : assert property (@(posedge clk) disable iff (rst)
    $onehot0({net_mem_wr.we, pc_wr.max_we, pc_wr.loop_we}))
    else $error("switch_conf_reader: more than one strobe");

endmodule

`default_nettype wire

// File: design/switch_context.sv
`default_nettype none

module switch_context (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        run,
  input  cgra_net_pkg::net_mem_wr_t   net_mem_wr,
  input  cgra_net_pkg::pc_wr_t        pc_wr,
  output cgra_net_pkg::switch_state_t switch_state
);

  import cgra_net_pkg::*;

  logic [SEL_W-1:0] mem [2**PC_W];
  logic [PC_W-1:0]  pc;
  logic [PC_W-1:0]  pc_max;
  logic [PC_W-1:0]  pc_loop;
  logic [PC_W-1:0]  pc_next;
  logic [2:0]       thread;
  logic [SEL_W-1:0] sel;
  logic             active;

  // first running cycle reports pc 0, then the loop rule applies
  always_comb begin
    if (!run || !active) begin
      pc_next = '0;
    end else if (pc == pc_max) begin
      pc_next = pc_loop;
    end else begin
      pc_next = pc + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (net_mem_wr.we) begin
      mem[net_mem_wr.addr] <= net_mem_wr.data;
    end
    if (net_mem_wr.we && net_mem_wr.addr == pc_next) begin
      sel <= net_mem_wr.data;  // write through to the reported slot
    end else begin
      sel <= mem[pc_next];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= '0;
      pc_max  <= '0;
      pc_loop <= '0;
      thread  <= '0;
      active  <= 1'b0;
    end else begin
      pc     <= pc_next;
      active <= run;
      if (pc_wr.max_we) begin
        pc_max <= pc_wr.value;
      end
      if (pc_wr.loop_we) begin
        pc_loop <= pc_wr.value;
      end
      if (pc_wr.thread_we) begin
        thread <= pc_wr.thread;
      end
    end
  end

  assign switch_state.active = active;
  assign switch_state.pc     = pc;
  assign switch_state.sel    = sel;
  assign switch_state.thread = thread;

endmodule

`default_nettype wire

// File: design/cgra_net_conf_top.sv
`default_nettype none

module cgra_net_conf_top #(
  parameter int NUM_SWITCHES = 2,
  parameter int FIFO_DEPTH   = 4
) (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          host_req,
  input  cgra_conf_pkg::conf_word_t                     host_word,
  output logic                                          host_ack,
  input  logic                                          conf_hold,
  input  logic                                          run,
  output cgra_net_pkg::switch_state_t [NUM_SWITCHES-1:0] switch_states
);

  import cgra_conf_pkg::*;
  import cgra_net_pkg::*;

  logic        push;
  conf_word_t  push_word;
  logic        full;
  conf_bus_t   conf_bus;
  net_mem_wr_t net_mem_wr [NUM_SWITCHES];
  pc_wr_t      pc_wr      [NUM_SWITCHES];

  conf_ingress u_ingress (
    .clk       (clk),
    .rst       (rst),
    .host_req  (host_req),
    .host_word (host_word),
    .host_ack  (host_ack),
    .full      (full),
    .push      (push),
    .push_word (push_word)
  );

  conf_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_word (push_word),
    .full      (full),
    .conf_hold (conf_hold),
    .conf_bus  (conf_bus)
  );

  for (genvar i = 0; i < NUM_SWITCHES; i++) begin : g_switch
    switch_conf_reader #(.SWITCH_NUMBER(i)) u_reader (
      .clk        (clk),
      .rst        (rst),
      .conf_bus   (conf_bus),
      .net_mem_wr (net_mem_wr[i]),
      .pc_wr      (pc_wr[i])
    );

    switch_context u_context (
      .clk          (clk),
      .rst          (rst),
      .run          (run),
      .net_mem_wr   (net_mem_wr[i]),
      .pc_wr        (pc_wr[i]),
      .switch_state (switch_states[i])
    );
  end

endmodule

`default_nettype wire

// File: test/tb_cgra_net_conf.sv
`default_nettype none

module tb_cgra_net_conf;

  import cgra_conf_pkg::*;
  import cgra_net_pkg::*;

  localparam int NUM_SWITCHES = 2;  // dut defaults
  localparam int FIFO_DEPTH   = 4;
  localparam int CLK_PERIOD   = 40;
  localparam int HS_BOUND     = 16;              // cycles allowed per handshake phase
  localparam int SETTLE       = FIFO_DEPTH + 4;  // drain, two reader stages, write
  localparam int HOLD_CYCLES  = 6;
  localparam int RUN_CYCLES   = 24;
  localparam int T2_WORDS     = 8 * NUM_SWITCHES + 4 + 2 * NUM_SWITCHES;
  localparam int T3_WORDS     = 2 * NUM_SWITCHES;
  localparam int T4_WORDS     = 9;
  localparam int T5_WORDS     = FIFO_DEPTH + 3;
  localparam int WATCHDOG_CYCLES = (2 * HS_BOUND + 1) * (T2_WORDS + T3_WORDS + T4_WORDS + T5_WORDS)
                                 + 4 * (RUN_CYCLES + 3 + SETTLE) + HOLD_CYCLES + 40;

  logic                             clk;
  logic                             rst;
  logic                             host_req;
  conf_word_t                       host_word;
  logic                             host_ack;
  logic                             conf_hold;
  logic                             run;
  switch_state_t [NUM_SWITCHES-1:0] switch_states;

  logic [31:0]      rng_state;
  logic [SEL_W-1:0] model_mem     [NUM_SWITCHES][2**PC_W];
  bit               model_written [NUM_SWITCHES][2**PC_W];
  logic [PC_W-1:0]  model_max     [NUM_SWITCHES];
  logic [PC_W-1:0]  model_loop    [NUM_SWITCHES];
  logic [2:0]       model_thread  [NUM_SWITCHES];
  logic [PC_W-1:0]  prev_pc       [NUM_SWITCHES];
  bit               prev_valid    [NUM_SWITCHES];
  int               errors;
  int               checks;
  int               wraps;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  cgra_net_conf_top dut (
    .clk           (clk),
    .rst           (rst),
    .host_req      (host_req),
    .host_word     (host_word),
    .host_ack      (host_ack),
    .conf_hold     (conf_hold),
    .run           (run),
    .switch_states (switch_states)
  );

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // loop back at pc_max, else count up
  function automatic logic [PC_W-1:0] expected_next_pc(input logic [PC_W-1:0] pc,
                                                       input logic [PC_W-1:0] max,
                                                       input logic [PC_W-1:0] loop);
    if (pc == max) begin
      return loop;
    end
    return pc + PC_W'(1);
  endfunction

  function automatic conf_word_t net_word(input logic [15:0] sw, input logic [3:0] thr,
                                          input logic [11:0] addr, input logic [23:0] data);
    return conf_word_t'({addr, data, thr, sw, 8'd8});
  endfunction

  function automatic conf_word_t pc_word(input logic [7:0] kind, input logic [15:0] sw,
                                         input logic [3:0] thr, input logic [31:0] value);
    return conf_word_t'({4'h0, value, thr, sw, kind});
  endfunction

  // decode straight from the word's bit layout
  task automatic model_apply(input logic [63:0] w);
    int sw;
    sw = int'(w[23:8]);
    if (w[23:8] < 16'(NUM_SWITCHES)) begin
      case (w[7:0])
        8'd6: begin
          model_max[sw]    = w[35:28];
          model_thread[sw] = w[26:24];
        end
        8'd7: begin
          model_loop[sw]   = w[35:28];
          model_thread[sw] = w[26:24];
        end
        8'd8: begin
          model_mem[sw][w[59:52]]     = w[35:28];
          model_written[sw][w[59:52]] = 1'b1;
          model_thread[sw]            = w[26:24];
        end
        default: begin
        end  // pe and unknown types
      endcase
    end
  endtask

  task automatic raise_req(input conf_word_t w);
    @(posedge clk);
    host_word <= w;
    host_req  <= 1'b1;
  endtask

  task automatic complete_req(input conf_word_t w);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!host_ack && n < HS_BOUND);
    checks++;
    assert (host_ack) else begin
      $display("time %0t: no ack from ingress within %0d cycles", $time, HS_BOUND);
      errors++;
    end
    host_req <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (host_ack && n < HS_BOUND);
    checks++;
    assert (!host_ack) else begin
      $display("time %0t: ack still high %0d cycles after req fell", $time, HS_BOUND);
      errors++;
    end
    model_apply(w);
  endtask

  task automatic send_word(input conf_word_t w);
    raise_req(w);
    complete_req(w);
  endtask

  task automatic settle();
    repeat (SETTLE) @(posedge clk);
  endtask

  task automatic run_for(input int cycles);
    @(posedge clk);
    run <= 1'b1;
    repeat (cycles) @(posedge clk);
    run <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic check_idle();
    checks++;
    assert (host_ack === 1'b0) else begin
      $display("MISMATCH time %0t signal host_ack expected 0 got %b", $time, host_ack);
      errors++;
    end
    for (int s = 0; s < NUM_SWITCHES; s++) begin
      checks++;
      assert (switch_states[s].active === 1'b0) else begin
        $display("MISMATCH time %0t signal switch_states[%0d].active expected 0 got %b",
                 $time, s, switch_states[s].active);
        errors++;
      end
    end
  endtask

  task automatic report_test(input string name, input int base);
    $display("test %s: %s (%0d errors)", name, (errors == base) ? "ok" : "FAILED", errors - base);
  endtask

  task automatic check_switch(input int s);
    switch_state_t   st;
    logic [PC_W-1:0] exp_pc;
    st     = switch_states[s];
    exp_pc = prev_valid[s] ? expected_next_pc(prev_pc[s], model_max[s], model_loop[s]) : '0;
    checks++;
    assert (st.pc == exp_pc) else begin
      $display("MISMATCH time %0t signal switch_states[%0d].pc expected %0d got %0d",
               $time, s, exp_pc, st.pc);
      errors++;
    end
    if (prev_valid[s] && prev_pc[s] == model_max[s] && st.pc == model_loop[s]) begin
      wraps++;
    end
    if (model_written[s][st.pc]) begin
      checks++;
      assert (st.sel == model_mem[s][st.pc]) else begin
        $display("MISMATCH time %0t signal switch_states[%0d].sel expected %h got %h",
                 $time, s, model_mem[s][st.pc], st.sel);
        errors++;
      end
    end
    checks++;
    assert (st.thread == model_thread[s]) else begin
      $display("MISMATCH time %0t signal switch_states[%0d].thread expected %0d got %0d",
               $time, s, model_thread[s], st.thread);
      errors++;
    end
    prev_pc[s]    = st.pc;
    prev_valid[s] = 1'b1;
  endtask

  // sample between edges, where outputs are stable
  initial begin : compare_outputs
    forever begin
      @(negedge clk);
      for (int s = 0; s < NUM_SWITCHES; s++) begin
        if (!run || !switch_states[s].active) begin
          prev_valid[s] = 1'b0;
        end else begin
          check_switch(s);
        end
      end
    end
  end

  initial begin : watchdog
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    int          base;
    int          wraps_before;
    logic [15:0] sw;
    conf_word_t  last;
    rng_state = 32'h04bc_0a36;
    errors    = 0;
    checks    = 0;
    wraps     = 0;
    rst       = 1'b1;
    host_req  = 1'b0;
    host_word = '0;
    conf_hold = 1'b0;
    run       = 1'b0;
    for (int s = 0; s < NUM_SWITCHES; s++) begin
      model_max[s]    = '0;
      model_loop[s]   = '0;
      model_thread[s] = '0;
      prev_valid[s]   = 1'b0;
      for (int a = 0; a < 2**PC_W; a++) begin
        model_written[s][a] = 1'b0;
      end
    end

    base = errors;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      if (i == 2) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      check_idle();
    end
    repeat (3) begin
      @(negedge clk);
      check_idle();
    end
    report_test("reset", base);

    base = errors;
    for (int a = 0; a < 8; a++) begin
      for (int s = 0; s < NUM_SWITCHES; s++) begin
        send_word(net_word(16'(s), 4'(next_rand()), {4'(next_rand()), 8'(a)}, 24'(next_rand())));
      end
    end
    for (int i = 0; i < 4; i++) begin
      send_word(net_word(16'(next_rand() % NUM_SWITCHES), 4'(next_rand()),
                         12'(next_rand() % 8), 24'(next_rand())));
    end
    for (int s = 0; s < NUM_SWITCHES; s++) begin
      send_word(pc_word(SET_NET_PC_MAX, 16'(s), 4'(next_rand()), {24'(next_rand()), 8'd7}));
      send_word(pc_word(SET_NET_PC_LOOP, 16'(s), 4'(next_rand()),
                        {24'(next_rand()), 8'(next_rand() % 8)}));
    end
    settle();
    run_for(RUN_CYCLES);
    report_test("net switch writes", base);

    base = errors;
    for (int s = 0; s < NUM_SWITCHES; s++) begin
      send_word(pc_word(SET_NET_PC_MAX, 16'(s), 4'(next_rand()), 32'd5));
      send_word(pc_word(SET_NET_PC_LOOP, 16'(s), 4'(next_rand()), 32'd2));
    end
    settle();
    wraps_before = wraps;
    run_for(RUN_CYCLES);
    checks++;
    assert (wraps - wraps_before >= 2 * NUM_SWITCHES) else begin
      $display("time %0t: pc wrapped from pc_max to pc_loop only %0d times",
               $time, wraps - wraps_before);
      errors++;
    end
    report_test("pc sequencing", base);

    base = errors;
    for (int i = 0; i < 4; i++) begin
      sw = 16'(next_rand());
      if (sw < 16'(NUM_SWITCHES)) begin
        sw = sw + 16'(NUM_SWITCHES);  // force a foreign switch
      end
      if (i % 2 == 0) begin
        send_word(net_word(sw, 4'(next_rand()), 12'(i), 24'(next_rand())));
      end else begin
        send_word(pc_word(SET_NET_PC_MAX, sw, 4'(next_rand()), 32'd1));
      end
    end
    for (int k = 1; k <= 5; k++) begin
      send_word(pc_word(8'(k), 16'(k % NUM_SWITCHES), 4'(next_rand()), next_rand()));
    end
    settle();
    run_for(RUN_CYCLES);
    report_test("filtering", base);

    base = errors;
    @(posedge clk);
    conf_hold <= 1'b1;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      send_word(net_word(16'd1, 4'(next_rand()), 12'd3, 24'(next_rand())));
    end
    last = net_word(16'd1, 4'(next_rand()), 12'd3, 24'(next_rand()));
    raise_req(last);
    repeat (HOLD_CYCLES) begin
      @(posedge clk);
      checks++;
      assert (!host_ack) else begin
        $display("time %0t: ingress acked a word while the buffer was full", $time);
        errors++;
      end
    end
    conf_hold <= 1'b0;
    complete_req(last);
    send_word(net_word(16'd0, 4'(next_rand()), 12'd4, 24'(next_rand())));
    send_word(net_word(16'd0, 4'(next_rand()), 12'd4, 24'(next_rand())));
    settle();
    run_for(RUN_CYCLES);
    report_test("back-pressure and ordering", base);

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
design/cgra_conf_pkg.sv
design/cgra_net_pkg.sv
design/conf_ingress.sv
design/conf_fifo.sv
design/switch_conf_reader.sv
design/switch_context.sv
design/cgra_net_conf_top.sv
test/tb_cgra_net_conf.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cgra_net_conf -f src.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
